// ==== filelist.f ====
rtl/env_pkg.sv
rtl/env_param_regs.sv
rtl/env_slot_scanner.sv
rtl/env_state_ram.sv
rtl/env_stepper.sv
rtl/env_gen_top.sv
tests/env_gen_tb.sv

// ==== Bender.yml ====
package:
  name: env_gen

sources:
  - rtl/env_pkg.sv
  - rtl/env_param_regs.sv
  - rtl/env_slot_scanner.sv
  - rtl/env_state_ram.sv
  - rtl/env_stepper.sv
  - rtl/env_gen_top.sv
  - target: test
    files:
      - tests/env_gen_tb.sv

// ==== tests/env_gen_tb.sv ====
// envelope generator testbench
`timescale 1ns/1ps
`default_nettype none

module env_gen_tb
    import env_pkg::*;
();

    localparam int CLK_NS    = 4;
    localparam int T_BOOT    = 24;          // reset plus clearing sweep
    localparam int T_QUIET   = 3 * NUM_SLOTS;
    localparam int T_PARAM   = 160;
    localparam int T_ATTACK  = 1600;
    localparam int T_RELEASE = 1600;
    localparam int T_RETRIG  = 900;
    localparam int T_RANDOM  = 2200;
    localparam int RUN_CYCLES = T_BOOT + T_QUIET + T_PARAM + T_ATTACK + T_RELEASE
                              + T_RETRIG + T_RANDOM;
    localparam int WATCHDOG_NS = RUN_CYCLES * CLK_NS * 3 / 2;
    localparam int PBITS = WB_DAT_W * NUM_ENVS * 2 * NUM_SEGS;

    logic                  read;
    logic                  iRST_N;
    wb_req_t               wb_req;
    wb_rsp_t               wb_rsp;
    logic [NUM_VOICES-1:0] keys_on;
    env_out_t              env_out;
    logic [NUM_VOICES-1:0] voice_free;

    integer                   seed;
    string                    test_name;
    int                       n_mismatch;
    int                       n_fail;
    int                       out_cnt;
    int                       cyc_cnt;
    logic [NUM_VOICES-1:0]    keys_s;       // keys seen by the last output edge
    logic [PBITS-1:0]         shadow;       // bytes as written over the bus
    logic [PBITS-1:0]         snap1;
    logic [PBITS-1:0]         snap2;
    env_state_t               model [NUM_SLOTS];
    logic [NUM_VOICES-1:0]    free_model;
    logic [VOICE_W+ENV_W-1:0] exp_slot;

    env_gen_top dut0 (
        .read       (read),
        .iRST_N     (iRST_N),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .keys_on    (keys_on),
        .env_out    (env_out),
        .voice_free (voice_free)
    );

    always #(CLK_NS / 2) read = ~read;

    always @(posedge read) begin
        cyc_cnt <= cyc_cnt + 1;
        keys_s  <= keys_on;
        snap1   <= shadow;      // what the param register loads now
        snap2   <= snap1;       // what the stepper used for this output
    end

    function automatic env_params_t params_of(input logic [PBITS-1:0] mem, input int env);
        env_params_t p;
        for (int k = 0; k < NUM_SEGS; k++) begin
            p.rate[k]  = mem[(env * 8 + k) * WB_DAT_W +: WB_DAT_W];
            p.level[k] = mem[(env * 8 + NUM_SEGS + k) * WB_DAT_W +: WB_DAT_W];
        end
        return p;
    endfunction

    // one visit of the step rule
    function automatic env_state_t ref_step(input env_state_t cur, input env_params_t p,
                                            input logic key);
        env_state_t res;
        int ph;
        int acc;
        int seg;
        int tgt;
        int rate;
        ph  = int'(cur.phase);
        acc = int'(cur.acc);
        if (key && ph == IDLE) begin
            ph  = SEG0;
            acc = 0;
        end else if (key && ph == RELEASE) begin
            ph = SEG0;          // keeps current level
        end else if (!key && ph != IDLE && ph != RELEASE) begin
            ph = RELEASE;
        end
        if (ph != IDLE && ph != SUSTAIN) begin
            seg  = (ph == RELEASE) ? 3 : ph - SEG0;
            tgt  = int'(p.level[seg]) * (1 << FRAC_W);
            rate = int'(p.rate[seg]);
            if (acc < tgt) begin
                acc = (acc + rate > tgt) ? tgt : acc + rate;
            end else begin
                acc = (acc - rate < tgt) ? tgt : acc - rate;
            end
            if (acc == tgt) begin
                ph = (ph == RELEASE) ? IDLE : ph + 1;
            end
        end
        res.phase = env_phase_e'(ph);
        res.acc   = LEVEL_W'(acc);
        return res;
    endfunction

    task automatic check_out(input env_out_t exp, input env_out_t act);
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch %s env_out: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    task automatic check_free(input logic [NUM_VOICES-1:0] exp,
                              input logic [NUM_VOICES-1:0] act);
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch %s voice_free: expected %b, actual %b", test_name, exp, act);
        end
    endtask

    task automatic check_rd(input logic [WB_DAT_W-1:0] exp, input logic [WB_DAT_W-1:0] act);
        if (act !== exp) begin
            n_mismatch++;
            $display("Mismatch %s read data: expected %h, actual %h", test_name, exp, act);
        end
    endtask

    // compare every output against the model
    always @(negedge read) begin
        env_state_t nxt;
        env_out_t   exp;
        int         s;
        if (iRST_N && env_out.valid === 1'b1) begin
            s   = int'(exp_slot);
            nxt = ref_step(model[s], params_of(snap2, s % NUM_ENVS), keys_s[s / NUM_ENVS]);
            model[s] = nxt;
            exp = '{valid: 1'b1, slot: slot_ref_t'(exp_slot), level: OUT_W'(nxt.acc >> FRAC_W)};
            check_out(exp, env_out);
            if (s % NUM_ENVS == MAIN_ENV) begin
                free_model[s / NUM_ENVS] = (nxt.phase == IDLE);
                check_free(free_model, voice_free);
            end
            exp_slot = exp_slot + 1'b1;
            out_cnt++;
        end else if (iRST_N && out_cnt > 0) begin
            n_fail++;
            $display("env_out.valid went low in the middle of the scan");
        end
    end

    // wishbone accesses start and end on a falling edge
    task automatic bus_access(input logic we, input logic [WB_ADR_W-1:0] adr,
                              input logic [WB_DAT_W-1:0] dat);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        do begin
            @(negedge read);
            waited++;
        end while (wb_rsp.ack !== 1'b1 && waited < 8);
        if (wb_rsp.ack !== 1'b1 || waited != 1) begin
            n_fail++;
            $display("access to address %0d: ack after %0d cycles instead of 1", adr, waited);
        end
        if (we) begin
            shadow[adr * WB_DAT_W +: WB_DAT_W] = dat;
        end else begin
            check_rd(shadow[adr * WB_DAT_W +: WB_DAT_W], wb_rsp.dat);
        end
        @(negedge read);                // hold through the ack edge
        wb_req = '0;
    endtask

    task automatic load_all(input logic [NUM_SEGS*WB_DAT_W-1:0] rates,
                            input logic [NUM_SEGS*WB_DAT_W-1:0] levels);
        for (int e = 0; e < NUM_ENVS; e++) begin
            for (int k = 0; k < NUM_SEGS; k++) begin
                bus_access(1'b1, WB_ADR_W'(e * 8 + k), rates[k * WB_DAT_W +: WB_DAT_W]);
                bus_access(1'b1, WB_ADR_W'(e * 8 + NUM_SEGS + k),
                           levels[k * WB_DAT_W +: WB_DAT_W]);
            end
        end
    endtask

    task automatic wait_outputs(input int n);
        int target;
        target = out_cnt + n;
        while (out_cnt < target) begin
            @(negedge read);
        end
    endtask

    task automatic wait_phase(input int s, input env_phase_e ph, input int max_cycles);
        int n;
        n = 0;
        @(posedge read);
        while (model[s].phase != ph && n < max_cycles) begin
            @(posedge read);
            n++;
        end
        if (model[s].phase != ph) begin
            n_fail++;
            $display("%s: slot %0d did not reach %s within %0d cycles",
                     test_name, s, ph.name(), max_cycles);
        end
        @(negedge read);
    endtask

    initial begin
        logic [31:0] r;
        int          start;
        read       = 1'b0;
        iRST_N     = 1'b0;
        wb_req     = '0;
        keys_on    = '0;
        seed       = 61;
        n_mismatch = 0;
        n_fail     = 0;
        out_cnt    = 0;
        cyc_cnt    = 0;
        shadow     = '0;
        free_model = '1;
        exp_slot   = '0;
        test_name  = "reset";
        for (int s = 0; s < NUM_SLOTS; s++) begin
            model[s] = '{phase: IDLE, acc: '0};     // after the clearing sweep
        end
        repeat (8) @(negedge read);
        iRST_N = 1'b1;

        test_name = "quiet start";
        wait_outputs(T_QUIET);
        check_free('1, voice_free);

        test_name = "parameter access";
        for (int a = 0; a < 32; a++) begin
            bus_access(1'b1, WB_ADR_W'(a), WB_DAT_W'($random(seed)));
        end
        for (int a = 0; a < 32; a++) begin
            bus_access(1'b0, WB_ADR_W'(a), '0);
        end

        test_name = "attack";
        load_all({8'd255, 8'd128, 8'd200, 8'd255}, {8'd0, 8'd32, 8'd24, 8'd40});
        keys_on = 4'b0010;
        wait_phase(1 * NUM_ENVS + MAIN_ENV, SUSTAIN, T_ATTACK);
        wait_outputs(2 * NUM_SLOTS);                    // sustain holds

        test_name = "release";
        keys_on = 4'b0110;
        wait_phase(2 * NUM_ENVS + MAIN_ENV, SEG1, T_RELEASE);
        keys_on = 4'b0000;                              // one in a segment, one in sustain
        wait_phase(2 * NUM_ENVS + MAIN_ENV, IDLE, T_RELEASE);
        wait_phase(1 * NUM_ENVS + MAIN_ENV, IDLE, T_RELEASE);
        wait_outputs(NUM_SLOTS);
        check_free('1, voice_free);

        test_name = "retrigger";
        keys_on = 4'b0001;
        wait_phase(MAIN_ENV, SEG1, T_RETRIG);
        keys_on = 4'b0000;
        wait_phase(MAIN_ENV, RELEASE, 2 * NUM_SLOTS);
        keys_on = 4'b0001;
        wait_phase(MAIN_ENV, SEG1, T_RETRIG);

        test_name = "random run";
        for (int a = 0; a < 32; a++) begin
            bus_access(1'b1, WB_ADR_W'(a), WB_DAT_W'($random(seed)));
        end
        start = cyc_cnt;
        while (cyc_cnt < start + 2000) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                keys_on = r[11:8];
            end
            if (r[7:3] == 5'd0) begin
                bus_access(1'b1, WB_ADR_W'(r >> 12), WB_DAT_W'(r >> 20));
            end else begin
                @(negedge read);
            end
        end
        keys_on = '0;
        wait_outputs(2 * NUM_SLOTS);

        $display("done: %0d mismatches, %0d other errors, %0d outputs checked",
                 n_mismatch, n_fail, out_cnt);
        if (n_mismatch == 0 && n_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run still going after %0d ns in %s", WATCHDOG_NS, test_name);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/env_gen_top.sv ====
// envelope generator top
`timescale 1ns/1ps
`default_nettype none

module env_gen_top
    import env_pkg::*;
(
    input  wire                   read,
    input  wire                   iRST_N,
    input  wb_req_t               wb_req,
    output wb_rsp_t               wb_rsp,
    input  wire [NUM_VOICES-1:0]  keys_on,
    output env_out_t              env_out,
    output wire [NUM_VOICES-1:0]  voice_free
);

    slot_ref_t   scan_slot;
    logic        scan_valid;
    logic        clear_we;
    env_state_t  rd_state;
    env_params_t params;
    logic        step_we;
    env_state_t  step_state;
    logic        ram_we;
    slot_ref_t   ram_wr_slot;
    env_state_t  ram_wr_state;

    env_slot_scanner u_scan (
        .read       (read),
        .iRST_N     (iRST_N),
        .slot       (scan_slot),
        .slot_valid (scan_valid),
        .clear_we   (clear_we)
    );

    env_param_regs u_regs (
        .read      (read),
        .iRST_N    (iRST_N),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .param_env (scan_slot.env),
        .params    (params)
    );

    // sweep owns the write port, otherwise the slot read one cycle ago
    assign ram_we       = clear_we | step_we;
    assign ram_wr_slot  = clear_we ? scan_slot : slot_ref_t'(scan_slot - 1'b1);
    assign ram_wr_state = clear_we ? env_state_t'{phase: IDLE, acc: '0} : step_state;

    env_state_ram u_ram (
        .read     (read),
        .rd_slot  (scan_slot),
        .rd_state (rd_state),
        .wr_en    (ram_we),
        .wr_slot  (ram_wr_slot),
        .wr_state (ram_wr_state)
    );

    env_stepper u_step (
        .read       (read),
        .iRST_N     (iRST_N),
        .in_valid   (scan_valid),
        .in_slot    (scan_slot),
        .state      (rd_state),
        .params     (params),
        .keys_on    (keys_on),
        .wr_en      (step_we),
        .wr_state   (step_state),
        .env_out    (env_out),
        .voice_free (voice_free)
    );

endmodule

`default_nettype wire

// ==== rtl/env_stepper.sv ====
// envelope stepper
`timescale 1ns/1ps
`default_nettype none

module env_stepper
    import env_pkg::*;
(
    input  wire                  read,
    input  wire                  iRST_N,
    input  wire                  in_valid,
    input  slot_ref_t            in_slot,
    input  env_state_t           state,
    input  env_params_t          params,
    input  wire [NUM_VOICES-1:0] keys_on,
    output logic                 wr_en,
    output env_state_t           wr_state,
    output env_out_t             env_out,
    output logic [NUM_VOICES-1:0] voice_free
);

    logic               valid_q;
    slot_ref_t          slot_q;
    logic               key;
    env_phase_e         ph;        // phase after key handling
    logic [LEVEL_W-1:0] acc0;
    logic [LEVEL_W-1:0] acc_n;
    logic [1:0]         seg;
    logic               ramp;
    logic [LEVEL_W-1:0] target;
    logic [LEVEL_W-1:0] step;
    logic [LEVEL_W:0]   up;
    env_state_t         nxt;
    logic               out_valid;
    slot_ref_t          out_slot;
    logic [OUT_W-1:0]   out_level;

    // line up with the memory read
    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    always_ff @(posedge read) begin
        slot_q <= in_slot;
    end

    always_comb begin
        key  = keys_on[slot_q.voice];
        ph   = state.phase;
        acc0 = state.acc;
        if (key && state.phase == IDLE) begin
            ph   = SEG0;
            acc0 = '0;
        end else if (key && state.phase == RELEASE) begin
            ph = SEG0;                                  // retrigger from current level
        end else if (!key && state.phase != IDLE && state.phase != RELEASE) begin
            ph = RELEASE;
        end

        ramp = 1'b1;
        case (ph)
            SEG0:    seg = 2'd0;
            SEG1:    seg = 2'd1;
            SEG2:    seg = 2'd2;
            RELEASE: seg = 2'd3;
            default: begin
                seg  = 2'd0;
                ramp = 1'b0;                            // idle or sustain hold
            end
        endcase

        target = LEVEL_W'(params.level[seg]) << FRAC_W;
        step   = LEVEL_W'(params.rate[seg]);
        up     = {1'b0, acc0} + {1'b0, step};

        if (!ramp) begin
            acc_n = acc0;
        end else if (acc0 < target) begin
            acc_n = (up >= {1'b0, target}) ? target : up[LEVEL_W-1:0];
        end else if (acc0 - target <= step) begin
            acc_n = target;
        end else begin
            acc_n = acc0 - step;
        end

        nxt.acc   = acc_n;
        nxt.phase = ph;
        if (ramp && acc_n == target) begin
            case (ph)
                SEG0:    nxt.phase = SEG1;
                SEG1:    nxt.phase = SEG2;
                SEG2:    nxt.phase = SUSTAIN;
                default: nxt.phase = IDLE;              // release done
            endcase
        end
    end

    assign wr_en    = valid_q;
    assign wr_state = nxt;

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            out_valid  <= 1'b0;
            voice_free <= '1;
        end else begin
            out_valid <= valid_q;
            if (valid_q && slot_q.env == ENV_W'(MAIN_ENV)) begin
                voice_free[slot_q.voice] <= (nxt.phase == IDLE);
            end
        end
    end

    always_ff @(posedge read) begin
        out_slot  <= slot_q;
        out_level <= nxt.acc[LEVEL_W-1 -: OUT_W];
    end

    assign env_out = '{valid: out_valid, slot: out_slot, level: out_level};

    // a segment ramp stays between the stored level and its target
    seg_no_overshoot: assert property (@(posedge read) disable iff (!iRST_N)
        (wr_en && ph inside {SEG0, SEG1, SEG2}) |->
            ((acc0 <= target) ? (wr_state.acc >= acc0 && wr_state.acc <= target)
                              : (wr_state.acc <= acc0 && wr_state.acc >= target)));

endmodule

`default_nettype wire

// ==== rtl/env_state_ram.sv ====
// per-slot envelope state memory
`timescale 1ns/1ps
`default_nettype none

module env_state_ram
    import env_pkg::*;
(
    input  wire        read,
    input  slot_ref_t  rd_slot,
    output env_state_t rd_state,
    input  wire        wr_en,
    input  slot_ref_t  wr_slot,
    input  env_state_t wr_state
);

    env_state_t mem [NUM_SLOTS];
    logic [VOICE_W+ENV_W-1:0] rd_idx;
    logic [VOICE_W+ENV_W-1:0] wr_idx;

    assign rd_idx = rd_slot;
    assign wr_idx = wr_slot;

    always_ff @(posedge read) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_state;
        end
        rd_state <= mem[rd_idx];     // sync read
    end

endmodule

`default_nettype wire

// ==== rtl/env_slot_scanner.sv ====
// slot scanner
`timescale 1ns/1ps
`default_nettype none

module env_slot_scanner
    import env_pkg::*;
(
    input  wire       read,
    input  wire       iRST_N,
    output slot_ref_t slot,
    output logic      slot_valid,
    output logic      clear_we
);

    logic [VOICE_W+ENV_W-1:0] cnt;   // voice*4 + env

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            cnt        <= '0;
            clear_we   <= 1'b1;      // init sweep first
            slot_valid <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;
            if (clear_we && cnt == (NUM_SLOTS - 1)) begin
                clear_we   <= 1'b0;
                slot_valid <= 1'b1;
            end
        end
    end

    assign slot = slot_ref_t'(cnt);

    // sweep and scan never overlap
    scan_excl: assert property (@(posedge read) disable iff (!iRST_N)
        !(clear_we && slot_valid));

endmodule

`default_nettype wire

// ==== rtl/env_param_regs.sv ====
// envelope parameter registers
`timescale 1ns/1ps
`default_nettype none

module env_param_regs
    import env_pkg::*;
(
    input  wire               read,
    input  wire               iRST_N,
    input  wb_req_t           wb_req,
    output wb_rsp_t           wb_rsp,
    input  wire [ENV_W-1:0]   param_env,
    output env_params_t       params
);

    logic [WB_DAT_W-1:0] mem [NUM_ENVS][2*NUM_SEGS];   // R0..R3 then L0..L3
    logic                req;
    logic                take;
    logic                ack_q;
    logic [WB_DAT_W-1:0] rd_dat;
    logic [ENV_W-1:0]    wb_env;
    logic [ENV_BYTE_W-1:0] wb_byte;

    assign req     = wb_req.cyc && wb_req.stb;
    assign take    = req && !ack_q;                     // one ack per request
    assign wb_env  = wb_req.adr[WB_ADR_W-1 -: ENV_W];
    assign wb_byte = wb_req.adr[ENV_BYTE_W-1:0];

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            ack_q <= 1'b0;
            for (int e = 0; e < NUM_ENVS; e++) begin
                for (int b = 0; b < 2*NUM_SEGS; b++) begin
                    mem[e][b] <= '0;
                end
            end
        end else begin
            ack_q <= take;
            if (take && wb_req.we) begin
                mem[wb_env][wb_byte] <= wb_req.dat;     // lands with ack
            end
        end
    end

    always_ff @(posedge read) begin
        if (take) begin
            rd_dat <= mem[wb_env][wb_byte];
        end
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat};

    // parameter set of the envelope under scan, one cycle later
    always_ff @(posedge read) begin
        for (int k = 0; k < NUM_SEGS; k++) begin
            params.rate[k]  <= mem[param_env][k];
            params.level[k] <= mem[param_env][k + NUM_SEGS];
        end
    end

    // ack only answers a request that was raised the cycle before
    ack_has_req: assert property (@(posedge read) disable iff (!iRST_N)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb && $past(req)));

endmodule

`default_nettype wire

// ==== rtl/env_pkg.sv ====
// envelope generator shared types
`default_nettype none

package env_pkg;

    localparam int NUM_VOICES = 4;
    localparam int NUM_ENVS   = 4;
    localparam int VOICE_W    = 2;
    localparam int ENV_W      = 2;
    localparam int NUM_SLOTS  = NUM_VOICES * NUM_ENVS;
    localparam int MAIN_ENV   = 1;                  // main volume envelope
    localparam int NUM_SEGS   = 4;                  // rate/level pairs per envelope
    localparam int ENV_BYTE_W = 3;                  // byte offset inside one envelope
    localparam int FRAC_W     = 8;
    localparam int LEVEL_W    = 16;                 // 8.8 accumulator
    localparam int OUT_W      = LEVEL_W - FRAC_W;
    localparam int WB_ADR_W   = 5;
    localparam int WB_DAT_W   = 8;

    typedef struct packed {
        logic [VOICE_W-1:0] voice;
        logic [ENV_W-1:0]   env;
    } slot_ref_t;

    typedef struct packed {
        logic [NUM_SEGS-1:0][WB_DAT_W-1:0] rate;    // R3..R0
        logic [NUM_SEGS-1:0][WB_DAT_W-1:0] level;   // L3..L0
    } env_params_t;

    typedef enum logic [2:0] {
        IDLE,
        SEG0,
        SEG1,
        SEG2,
        SUSTAIN,
        RELEASE
    } env_phase_e;

    typedef struct packed {
        env_phase_e         phase;
        logic [LEVEL_W-1:0] acc;
    } env_state_t;

    typedef struct packed {
        logic             valid;
        slot_ref_t        slot;
        logic [OUT_W-1:0] level;
    } env_out_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire
